// ==== common/datapath_params.svh ====
`ifndef DATAPATH_PARAMS_SVH
`define DATAPATH_PARAMS_SVH

// Machine word width.
`define DP_XLEN 32

// Architectural register file.
`define DP_NREGS 32
`define DP_REGIDX 5

// Branch-and-link writes the return address to $31.
`define DP_LINKREG 31

// Return address is the instruction address plus two words.
`define DP_LINKOFS 8

`endif

// ==== common/mipsAluPkg.sv ====
`include "datapath_params.svh"

package mipsAluPkg;

    // One strobe per function, driven straight from the decoder.
    typedef struct packed {
        logic add;
        logic sub;
        logic isUnsigned;      // Mul/div operand signedness.
        logic orOp;
        logic andOp;
        logic xorOp;

        logic sl;
        logic sr;
        logic arithmetic;      // Right shift keeps the sign bit.

        logic mul;
        logic div;

        logic writeHi;         // mthi.
        logic writeLo;         // mtlo.
        logic readHi;          // mfhi.
        logic readLo;          // mflo.

        logic boolean;         // Logic group drives the result.
    } aluCtrl_t;

    typedef struct packed {
        logic n;               // Result sign.
        logic z;               // Result zero.
        logic eq;              // Operands equal.
    } aluFlags_t;

    // Multiply puts the upper word in hi, divide puts the remainder there.
    typedef struct packed {
        logic [`DP_XLEN-1:0] hi;
        logic [`DP_XLEN-1:0] lo;
    } hiLo_t;

endpackage

// ==== common/mipsDatapathPkg.sv ====
`include "datapath_params.svh"

package mipsDatapathPkg;

    // Second ALU operand selection.
    typedef struct packed {
        logic        aluSrc;      // Immediate path instead of rt.
        logic        shiftAmt;    // Shamt instead of the immediate.
        logic [4:0]  shamt;
        logic [15:0] immediate;
    } operandCtrl_t;

    // Write-back control.
    typedef struct packed {
        logic regWrite;
        logic memToReg;           // Load data instead of the ALU result.
        logic regDst;             // Write rd instead of rt.
        logic bLink;              // Return address to $31.
    } wbCtrl_t;

    // Register fields of the instruction.
    typedef struct packed {
        logic [`DP_REGIDX-1:0] rs;
        logic [`DP_REGIDX-1:0] rt;
        logic [`DP_REGIDX-1:0] rd;
    } regAddr_t;

endpackage

// ==== src/regFile.sv ====
`timescale 1ns/10ps
`include "datapath_params.svh"

module regFile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wen,
    input  logic [`DP_REGIDX-1:0] writeAddr,
    input  logic [`DP_XLEN-1:0]   writeData,
    input  logic [`DP_REGIDX-1:0] readAddr0,
    input  logic [`DP_REGIDX-1:0] readAddr1,
    output logic [`DP_XLEN-1:0]   readData0,
    output logic [`DP_XLEN-1:0]   readData1,
    output logic [`DP_XLEN-1:0]   registerV0
);

    logic [`DP_XLEN-1:0] regs [`DP_NREGS];

    // Single write port, $0 is never written.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DP_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous reads.
    always_comb begin
        if (readAddr0 == '0) begin
            readData0 = '0;       // Hard-wired zero.
        end else begin
            readData0 = regs[readAddr0];
        end

        if (readAddr1 == '0) begin
            readData1 = '0;
        end else begin
            readData1 = regs[readAddr1];
        end
    end

    assign registerV0 = regs[2];  // $v0 for observation.

endmodule

// ==== alu/hiLoUnit.sv ====
`timescale 1ns/10ps
`include "datapath_params.svh"

module hiLoUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [`DP_XLEN-1:0]  op1,
    input  logic [`DP_XLEN-1:0]  op2,
    input  mipsAluPkg::aluCtrl_t aluCtrl,
    output mipsAluPkg::hiLo_t    hiLo
);

    import mipsAluPkg::*;

    logic signed [2*`DP_XLEN-1:0] signedProd;
    logic [2*`DP_XLEN-1:0]        unsignedProd;
    logic [`DP_XLEN-1:0]          safeDivisor;
    logic                         divByZero;
    hiLo_t                        product;
    hiLo_t                        divResult;

    assign signedProd   = $signed(op1) * $signed(op2);
    assign unsignedProd = op1 * op2;
    assign product      = aluCtrl.isUnsigned ? unsignedProd : signedProd;

    // Divisor forced to one on zero so the unused result stays defined.
    assign divByZero   = (op2 == '0);
    assign safeDivisor = divByZero ? `DP_XLEN'(1) : op2;

    always_comb begin
        if (aluCtrl.isUnsigned) begin
            divResult.lo = op1 / safeDivisor;
            divResult.hi = op1 % safeDivisor;
        end else begin
            divResult.lo = $signed(op1) / $signed(safeDivisor);
            divResult.hi = $signed(op1) % $signed(safeDivisor);  // Sign follows dividend.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hiLo <= '0;
        end else if (aluCtrl.mul) begin
            hiLo <= product;
        end else if (aluCtrl.div) begin
            if (!divByZero) begin
                hiLo <= divResult;
            end
        end else begin
            if (aluCtrl.writeHi) hiLo.hi <= op1;
            if (aluCtrl.writeLo) hiLo.lo <= op1;
        end
    end

endmodule

// ==== alu/aluCore.sv ====
`timescale 1ns/10ps
`include "datapath_params.svh"

module aluCore (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`DP_XLEN-1:0]   op1,
    input  logic [`DP_XLEN-1:0]   op2,
    input  mipsAluPkg::aluCtrl_t  aluCtrl,
    output logic [`DP_XLEN-1:0]   aluOut,
    output mipsAluPkg::aluFlags_t flags
);

    import mipsAluPkg::*;

    localparam int ShiftW = $clog2(`DP_XLEN);

    hiLo_t               hiLo;
    logic [ShiftW-1:0]   shAmt;
    logic [`DP_XLEN-1:0] sum;
    logic [`DP_XLEN-1:0] diff;
    logic [`DP_XLEN-1:0] logicRes;
    logic [`DP_XLEN-1:0] shiftRes;
    logic [`DP_XLEN-1:0] arithRes;

    hiLoUnit uHiLo (
        .clk     (clk),
        .reset   (reset),
        .op1     (op1),
        .op2     (op2),
        .aluCtrl (aluCtrl),
        .hiLo    (hiLo)
    );

    assign sum   = op1 + op2;
    assign diff  = op1 - op2;
    assign shAmt = op2[ShiftW-1:0];

    always_comb begin
        if (aluCtrl.orOp) begin
            logicRes = op1 | op2;
        end else if (aluCtrl.andOp) begin
            logicRes = op1 & op2;
        end else if (aluCtrl.xorOp) begin
            logicRes = op1 ^ op2;
        end else begin
            logicRes = '0;
        end
    end

    always_comb begin
        if (aluCtrl.sl) begin
            shiftRes = op1 << shAmt;
        end else if (aluCtrl.arithmetic) begin
            shiftRes = $signed(op1) >>> shAmt;   // sra.
        end else begin
            shiftRes = op1 >> shAmt;
        end
    end

    // Signedness makes no difference to the wrapped sum.
    always_comb begin
        if (aluCtrl.sub) begin
            arithRes = diff;
        end else if (aluCtrl.add) begin
            arithRes = sum;
        end else begin
            arithRes = '0;
        end
    end

    // Result priority: Hi, Lo, logic, shift, add/sub.
    always_comb begin
        if (aluCtrl.readHi) begin
            aluOut = hiLo.hi;
        end else if (aluCtrl.readLo) begin
            aluOut = hiLo.lo;
        end else if (aluCtrl.boolean) begin
            aluOut = logicRes;
        end else if (aluCtrl.sl || aluCtrl.sr) begin
            aluOut = shiftRes;
        end else begin
            aluOut = arithRes;
        end
    end

    always_comb begin
        flags.n  = aluOut[`DP_XLEN-1];
        flags.z  = (aluOut == '0);
        flags.eq = (op1 == op2);          // For beq/bne.
    end

endmodule

// ==== src/datapath.sv ====
`timescale 1ns/10ps
`include "datapath_params.svh"

module datapath (
    input  logic                          clk,
    input  logic                          reset,

    // Decoded control.
    input  mipsDatapathPkg::wbCtrl_t      wbCtrl,
    input  mipsDatapathPkg::operandCtrl_t opCtrl,
    input  mipsAluPkg::aluCtrl_t          aluCtrl,
    input  mipsDatapathPkg::regAddr_t     regAddr,

    input  logic [`DP_XLEN-1:0]           instrAddress,
    input  logic [`DP_XLEN-1:0]           dataReadData,

    output logic [`DP_XLEN-1:0]           readData0,
    output logic [`DP_XLEN-1:0]           registerV0,
    output logic [`DP_XLEN-1:0]           aluOut,
    output mipsAluPkg::aluFlags_t         flags
);

    logic [`DP_XLEN-1:0]   readData1;
    logic [`DP_XLEN-1:0]   op2;
    logic [`DP_XLEN-1:0]   writeData;
    logic [`DP_REGIDX-1:0] writeAddr;

    // Write-back source and destination.
    always_comb begin
        if (wbCtrl.bLink) begin
            writeData = instrAddress + `DP_XLEN'(`DP_LINKOFS);  // Return address.
            writeAddr = `DP_REGIDX'(`DP_LINKREG);
        end else begin
            writeData = wbCtrl.memToReg ? dataReadData : aluOut;
            writeAddr = wbCtrl.regDst ? regAddr.rd : regAddr.rt;
        end
    end

    regFile uRegFile (
        .clk        (clk),
        .reset      (reset),
        .wen        (wbCtrl.regWrite),
        .writeAddr  (writeAddr),
        .writeData  (writeData),
        .readAddr0  (regAddr.rs),
        .readAddr1  (regAddr.rt),
        .readData0  (readData0),
        .readData1  (readData1),
        .registerV0 (registerV0)
    );

    // Second operand, both immediate forms sign-extended.
    always_comb begin
        if (opCtrl.aluSrc && opCtrl.shiftAmt) begin
            op2 = {{(`DP_XLEN-5){opCtrl.shamt[4]}}, opCtrl.shamt};
        end else if (opCtrl.aluSrc) begin
            op2 = {{(`DP_XLEN-16){opCtrl.immediate[15]}}, opCtrl.immediate};
        end else begin
            op2 = readData1;
        end
    end

    // Op1 is always the rs port.
    aluCore uAlu (
        .clk     (clk),
        .reset   (reset),
        .op1     (readData0),
        .op2     (op2),
        .aluCtrl (aluCtrl),
        .aluOut  (aluOut),
        .flags   (flags)
    );

endmodule

// ==== dv/dvClockGen.sv ====
`timescale 1ns/10ps

module dvClockGen #(
    parameter int HalfPeriod  = 50,
    parameter int ResetCycles = 8
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    // Released on a falling edge, like the other inputs.
    initial begin
        reset = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

// ==== dv/datapath_assert.sv ====
`timescale 1ns/10ps
`include "datapath_params.svh"

module datapath_assert (
    input logic                  clk,
    input logic                  reset,
    input mipsDatapathPkg::regAddr_t regAddr,
    input mipsAluPkg::aluCtrl_t  aluCtrl,
    input logic [`DP_XLEN-1:0]   readData0,
    input logic [`DP_XLEN-1:0]   op2,
    input logic [`DP_XLEN-1:0]   aluOut,
    input mipsAluPkg::aluFlags_t flags,
    input mipsAluPkg::hiLo_t     hiLo
);

    int failures = 0;

    zeroRegRead: assert property (@(posedge clk) disable iff (reset)
        (regAddr.rs == '0) |-> (readData0 == '0))
        else begin
            failures++;
            $error("register 0 drove a nonzero value on readData0");
        end

    zeroFlag: assert property (@(posedge clk) disable iff (reset)
        flags.z == (aluOut == '0))
        else begin
            failures++;
            $error("flags.z disagrees with aluOut");
        end

    // Divide by zero must not touch Hi or Lo.
    divZeroHold: assert property (@(posedge clk) disable iff (reset)
        (aluCtrl.div && !aluCtrl.mul && (op2 == '0)) |=> (hiLo == $past(hiLo)))
        else begin
            failures++;
            $error("Hi/Lo changed on a divide by zero");
        end

endmodule

bind datapath datapath_assert uChecks (
    .clk       (clk),
    .reset     (reset),
    .regAddr   (regAddr),
    .aluCtrl   (aluCtrl),
    .readData0 (readData0),
    .op2       (op2),
    .aluOut    (aluOut),
    .flags     (flags),
    .hiLo      (uAlu.hiLo)
);

// ==== dv/datapathTb.sv ====
`timescale 1ns/10ps
`include "datapath_params.svh"

module datapathTb;

    import mipsAluPkg::*;
    import mipsDatapathPkg::*;

    localparam int SettleDelay  = 25;   // Quarter period after the falling edge.
    localparam int RandomRounds = 8;

    typedef enum logic [4:0] {
        OpNone, OpAdd, OpSub, OpOr, OpAnd, OpXor, OpSll, OpSrl, OpSra,
        OpMul, OpMulu, OpDiv, OpDivu, OpMthi, OpMtlo, OpMfhi, OpMflo
    } opKind_t;

    typedef enum logic [1:0] {ChkNone, ChkAlu, ChkV0, ChkRd0} chkKind_t;

    typedef struct packed {
        opKind_t             op;
        wbCtrl_t             wb;
        operandCtrl_t        opc;
        regAddr_t            ra;
        logic [`DP_XLEN-1:0] instrAddr;
        logic [`DP_XLEN-1:0] memData;
        chkKind_t            chk;
        logic [`DP_XLEN-1:0] exp;
        logic                expEq;
    } row_t;

    // Field order regWrite, memToReg, regDst, bLink.
    localparam wbCtrl_t WbNone  = 4'b0000;
    localparam wbCtrl_t WbRt    = 4'b1000;
    localparam wbCtrl_t WbRd    = 4'b1010;
    localparam wbCtrl_t WbMemRt = 4'b1100;
    localparam wbCtrl_t WbMemRd = 4'b1110;
    localparam wbCtrl_t WbLink  = 4'b1111;   // Link must win over the others.

    logic                clk;
    logic                reset;
    wbCtrl_t             wbCtrl;
    operandCtrl_t        opCtrl;
    aluCtrl_t            aluCtrl;
    regAddr_t            regAddr;
    logic [`DP_XLEN-1:0] instrAddress;
    logic [`DP_XLEN-1:0] dataReadData;
    logic [`DP_XLEN-1:0] readData0;
    logic [`DP_XLEN-1:0] registerV0;
    logic [`DP_XLEN-1:0] aluOut;
    aluFlags_t           flags;

    row_t rows[$];
    int   rowIdx    = 0;
    int   checks    = 0;
    int   errors    = 0;
    int   cycles    = 0;
    int   maxCycles = 0;

    dvClockGen uClk (.clk(clk), .reset(reset));

    datapath dut (
        .clk          (clk),
        .reset        (reset),
        .wbCtrl       (wbCtrl),
        .opCtrl       (opCtrl),
        .aluCtrl      (aluCtrl),
        .regAddr      (regAddr),
        .instrAddress (instrAddress),
        .dataReadData (dataReadData),
        .readData0    (readData0),
        .registerV0   (registerV0),
        .aluOut       (aluOut),
        .flags        (flags)
    );

    function automatic aluCtrl_t aluFor(opKind_t op);
        aluCtrl_t c;
        c = '0;
        case (op)
            OpAdd:  c.add = 1'b1;
            OpSub:  c.sub = 1'b1;
            OpOr:   c = '{orOp: 1'b1, boolean: 1'b1, default: 1'b0};
            OpAnd:  c = '{andOp: 1'b1, boolean: 1'b1, default: 1'b0};
            OpXor:  c = '{xorOp: 1'b1, boolean: 1'b1, default: 1'b0};
            OpSll:  c.sl = 1'b1;
            OpSrl:  c.sr = 1'b1;
            OpSra:  c = '{sr: 1'b1, arithmetic: 1'b1, default: 1'b0};
            OpMul:  c.mul = 1'b1;
            OpMulu: c = '{mul: 1'b1, isUnsigned: 1'b1, default: 1'b0};
            OpDiv:  c.div = 1'b1;
            OpDivu: c = '{div: 1'b1, isUnsigned: 1'b1, default: 1'b0};
            OpMthi: c.writeHi = 1'b1;
            OpMtlo: c.writeLo = 1'b1;
            OpMfhi: c.readHi = 1'b1;
            OpMflo: c.readLo = 1'b1;
            default: c = '0;
        endcase
        return c;
    endfunction

    function automatic operandCtrl_t immOp(logic [15:0] imm);
        return '{aluSrc: 1'b1, shiftAmt: 1'b0, shamt: 5'd0, immediate: imm};
    endfunction

    function automatic operandCtrl_t shOp(logic [4:0] sa);
        return '{aluSrc: 1'b1, shiftAmt: 1'b1, shamt: sa, immediate: 16'd0};
    endfunction

    function automatic regAddr_t regSel(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd);
        return '{rs: rs, rt: rt, rd: rd};
    endfunction

    function automatic logic [31:0] signExt16(logic [15:0] v);
        return {{16{v[15]}}, v};
    endfunction

    // Reference model for the register and immediate operations.
    function automatic logic [31:0] refAlu(opKind_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            OpAdd:   return a + b;
            OpSub:   return a - b;
            OpOr:    return a | b;
            OpAnd:   return a & b;
            OpXor:   return a ^ b;
            OpSll:   return a << b[4:0];
            OpSrl:   return a >> b[4:0];
            OpSra:   return $signed(a) >>> b[4:0];
            default: return '0;
        endcase
    endfunction

    // Returns {hi, lo}.
    function automatic logic [63:0] refMulDiv(opKind_t op, logic [31:0] a, logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        case (op)
            OpMul:   return sa * sb;
            OpMulu:  return {32'b0, a} * {32'b0, b};
            OpDiv:   return {$signed(a) % $signed(b), $signed(a) / $signed(b)};
            OpDivu:  return {a % b, a / b};
            default: return '0;
        endcase
    endfunction

    task automatic pushRow(input opKind_t op, input wbCtrl_t wb, input operandCtrl_t opc,
                           input regAddr_t ra, input chkKind_t chk,
                           input logic [31:0] exp, input logic expEq);
        row_t r;
        r = '0;
        r.op    = op;
        r.wb    = wb;
        r.opc   = opc;
        r.ra    = ra;
        r.chk   = chk;
        r.exp   = exp;
        r.expEq = expEq;
        rows.push_back(r);
    endtask

    // Memory load and link rows with no check of their own.
    task automatic pushIoRow(input wbCtrl_t wb, input regAddr_t ra,
                             input logic [31:0] instrAddr, input logic [31:0] memData);
        row_t r;
        r = '0;
        r.op        = OpNone;
        r.wb        = wb;
        r.ra        = ra;
        r.instrAddr = instrAddr;
        r.memData   = memData;
        r.chk       = ChkNone;
        rows.push_back(r);
    endtask

    task automatic buildDirected();
        pushRow(OpNone, WbNone, '0, regSel(0, 0, 0), ChkV0, 32'h0, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(1, 0, 0), ChkRd0, 32'h0, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(31, 0, 0), ChkRd0, 32'h0, 1'b0);
        pushRow(OpAdd, WbNone, '0, regSel(17, 30, 0), ChkAlu, 32'h0, 1'b1);
        pushRow(OpAdd, WbRt, immOp(16'h1234), regSel(0, 2, 0), ChkAlu, 32'h1234, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(0, 0, 0), ChkV0, 32'h1234, 1'b0);
        pushRow(OpAdd, WbRt, immOp(16'h00ff), regSel(0, 0, 0), ChkAlu, 32'hff, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(0, 0, 0), ChkRd0, 32'h0, 1'b0);
        // Operands r3 = 0xffff8005, r4 = 0x13.
        pushRow(OpAdd, WbRt, immOp(16'h8005), regSel(0, 3, 0), ChkAlu, 32'hffff8005, 1'b0);
        pushRow(OpAdd, WbRt, immOp(16'h0013), regSel(0, 4, 0), ChkAlu, 32'h13, 1'b0);
        pushRow(OpAdd, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'hffff8018, 1'b0);
        pushRow(OpSub, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'hffff7ff2, 1'b0);
        pushRow(OpSub, WbNone, '0, regSel(3, 3, 0), ChkAlu, 32'h0, 1'b1);
        pushRow(OpOr, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'hffff8017, 1'b0);
        pushRow(OpAnd, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'h1, 1'b0);
        pushRow(OpXor, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'hffff8016, 1'b0);
        pushRow(OpSll, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'h00280000, 1'b0);
        pushRow(OpSrl, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'h00001fff, 1'b0);
        pushRow(OpSra, WbNone, '0, regSel(3, 4, 0), ChkAlu, 32'hffffffff, 1'b0);
        pushRow(OpAdd, WbRd, '0, regSel(3, 4, 2), ChkAlu, 32'hffff8018, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(0, 0, 0), ChkV0, 32'hffff8018, 1'b0);
        pushRow(OpSll, WbNone, shOp(5'd4), regSel(4, 0, 0), ChkAlu, 32'h130, 1'b0);
        pushRow(OpSrl, WbNone, shOp(5'd4), regSel(3, 0, 0), ChkAlu, 32'h0ffff800, 1'b0);
        pushRow(OpSra, WbNone, shOp(5'd4), regSel(3, 0, 0), ChkAlu, 32'hfffff800, 1'b0);
        pushRow(OpAdd, WbNone, shOp(5'h1f), regSel(0, 0, 0), ChkAlu, 32'hffffffff, 1'b0);
        pushRow(OpOr, WbNone, immOp(16'h00f0), regSel(4, 0, 0), ChkAlu, 32'hf3, 1'b0);
        pushRow(OpAnd, WbNone, immOp(16'hfff0), regSel(3, 0, 0), ChkAlu, 32'hffff8000, 1'b0);
        pushRow(OpXor, WbNone, immOp(16'h8000), regSel(3, 0, 0), ChkAlu, 32'h5, 1'b0);
        pushRow(OpSub, WbNone, immOp(16'h0013), regSel(4, 0, 0), ChkAlu, 32'h0, 1'b1);
        pushRow(OpAdd, WbNone, immOp(16'hffff), regSel(4, 0, 0), ChkAlu, 32'h12, 1'b0);
        // Load data to rt, then to rd.
        pushIoRow(WbMemRt, regSel(0, 5, 0), 32'h0, 32'hdeadbeef);
        pushRow(OpNone, WbNone, '0, regSel(5, 0, 0), ChkRd0, 32'hdeadbeef, 1'b0);
        pushIoRow(WbMemRd, regSel(0, 5, 6), 32'h0, 32'hcafe0001);
        pushRow(OpNone, WbNone, '0, regSel(6, 0, 0), ChkRd0, 32'hcafe0001, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(5, 0, 0), ChkRd0, 32'hdeadbeef, 1'b0);
        pushIoRow(WbLink, regSel(0, 5, 7), 32'h00400010, 32'h12345678);
        pushRow(OpNone, WbNone, '0, regSel(31, 0, 0), ChkRd0, 32'h00400018, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(7, 0, 0), ChkRd0, 32'h0, 1'b0);
        pushRow(OpNone, WbNone, '0, regSel(5, 0, 0), ChkRd0, 32'hdeadbeef, 1'b0);
        // Hi/Lo results read back one cycle later.
        pushRow(OpMul, WbNone, '0, regSel(3, 4, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'hffffffff, 1'b1);
        pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'hfff6805f, 1'b1);
        pushRow(OpMulu, WbNone, '0, regSel(3, 4, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'h12, 1'b1);
        pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'hfff6805f, 1'b1);
        pushRow(OpDiv, WbNone, '0, regSel(3, 4, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'hfffffff9, 1'b1);
        pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'hfffff944, 1'b1);
        pushRow(OpDivu, WbNone, '0, regSel(3, 4, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'h12, 1'b1);
        pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'h0d793ca1, 1'b1);
        pushRow(OpDiv, WbNone, '0, regSel(3, 0, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'h12, 1'b1);
        pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'h0d793ca1, 1'b1);
        pushRow(OpMthi, WbNone, '0, regSel(4, 0, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMtlo, WbNone, '0, regSel(3, 0, 0), ChkNone, 32'h0, 1'b0);
        pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'h13, 1'b1);
        pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, 32'hffff8005, 1'b1);
    endtask

    task automatic buildRandom();
        logic [31:0] rnd;
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] hl;
        opKind_t     op;
        for (int i = 0; i < RandomRounds; i++) begin
            rnd = $urandom();
            a   = signExt16(rnd[15:0]);
            b   = (rnd[31:16] == '0) ? 32'h1 : signExt16(rnd[31:16]);   // No divide by zero.
            pushRow(OpAdd, WbRt, immOp(a[15:0]), regSel(0, 8, 0), ChkAlu, a, a == '0);
            pushRow(OpAdd, WbRt, immOp(b[15:0]), regSel(0, 9, 0), ChkAlu, b, 1'b0);
            op = opKind_t'(OpAdd + $urandom_range(0, 7));
            pushRow(op, WbNone, '0, regSel(8, 9, 0), ChkAlu, refAlu(op, a, b), a == b);
            op = opKind_t'(OpMul + $urandom_range(0, 3));
            hl = refMulDiv(op, a, b);
            pushRow(op, WbNone, '0, regSel(8, 9, 0), ChkNone, 32'h0, 1'b0);
            pushRow(OpMfhi, WbNone, '0, regSel(0, 0, 0), ChkAlu, hl[63:32], 1'b1);
            pushRow(OpMflo, WbNone, '0, regSel(0, 0, 0), ChkAlu, hl[31:0], 1'b1);
        end
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Error: %s = 0x%h, expected 0x%h (row %0d)", name, actual, expected, rowIdx);
        end
    endtask

    task automatic applyRow(input row_t r);
        wbCtrl       = r.wb;
        opCtrl       = r.opc;
        aluCtrl      = aluFor(r.op);
        regAddr      = r.ra;
        instrAddress = r.instrAddr;
        dataReadData = r.memData;
        #SettleDelay;
        case (r.chk)
            ChkAlu: begin
                checkValue("aluOut", aluOut, r.exp);
                checkValue("flags.n", flags.n, r.exp[31]);
                checkValue("flags.z", flags.z, r.exp == '0);
                checkValue("flags.eq", flags.eq, r.expEq);
            end
            ChkV0:   checkValue("registerV0", registerV0, r.exp);
            ChkRd0:  checkValue("readData0", readData0, r.exp);
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        cycles++;
        if (maxCycles > 0 && cycles >= maxCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", maxCycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h7784));
        wbCtrl       = '0;
        opCtrl       = '0;
        aluCtrl      = '0;
        regAddr      = '0;
        instrAddress = '0;
        dataReadData = '0;
        buildDirected();
        buildRandom();
        maxCycles = 2 * rows.size() + 50;

        @(negedge reset);
        foreach (rows[i]) begin
            @(negedge clk);
            rowIdx = i;
            applyRow(rows[i]);
        end
        @(negedge clk);

        $display("Summary: %0d rows, %0d checks, %0d errors, %0d assertion failures",
                 rows.size(), checks, errors, dut.uChecks.failures);
        if (errors == 0 && dut.uChecks.failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+common
common/mipsAluPkg.sv
common/mipsDatapathPkg.sv
src/regFile.sv
alu/hiLoUnit.sv
alu/aluCore.sv
src/datapath.sv
dv/dvClockGen.sv
dv/datapath_assert.sv
dv/datapathTb.sv

// ==== Bender.yml ====
package:
  name: mips_datapath

sources:
  - include_dirs:
      - common
    files:
      - common/mipsAluPkg.sv
      - common/mipsDatapathPkg.sv
      - src/regFile.sv
      - alu/hiLoUnit.sv
      - alu/aluCore.sv
      - src/datapath.sv

  - target: test
    include_dirs:
      - common
    files:
      - dv/dvClockGen.sv
      - dv/datapath_assert.sv
      - dv/datapathTb.sv
